/* hw/pci_target_pkg.sv */
package pci_target_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus types
	////////////////////////////////////////////////////////////////////////////
	typedef logic [31:0] addr_t;                  // PCI byte address
	typedef logic [31:0] data_t;                  // One 32 bit bus word
	typedef logic [3:0]  be_t;                    // Byte lanes (low active on PCI)
	typedef logic [3:0]  cmd_t;                   // Bus command from c_be in address phase
	typedef logic [2:0]  burst_cnt_t;             // Words moved in current burst

	////////////////////////////////////////////////////////////////////////////
	// PCI bus commands claimed by the target
	////////////////////////////////////////////////////////////////////////////
	localparam cmd_t CMD_MEM_READ      = 4'b0110; // Memory Read
	localparam cmd_t CMD_MEM_WRITE     = 4'b0111; // Memory Write
	localparam cmd_t CMD_MEM_READ_MULT = 4'b1100; // Memory Read Multiple
	localparam cmd_t CMD_MEM_READ_LINE = 4'b1110; // Memory Read Line

	////////////////////////////////////////////////////////////////////////////
	// Burst limits
	////////////////////////////////////////////////////////////////////////////
	// Read Multiple and Write run until the master stops or the window ends
	localparam int MEM_R_WORDS = 2;               // Memory Read disconnects after 2 words
	localparam int LINE_WORDS  = 4;               // One cache line

endpackage

/* hw/wb_if.sv */
`timescale 1ns/100ps

interface wb_if;
	import pci_target_pkg::*;

	addr_t adr;                                   // Byte address of the word
	data_t dat_w;                                 // Write data
	data_t dat_r;                                 // Read data
	be_t   sel;                                   // High active byte lanes
	logic  we;                                    // Write cycle
	logic  cyc;                                   // Cycle in progress
	logic  stb;                                   // Strobe
	logic  ack;                                   // One cycle acknowledge

	modport master (
		output adr,
		output dat_w,
		output sel,
		output we,
		output cyc,
		output stb,
		input  dat_r,
		input  ack
	);

	modport slave (
		input  adr,
		input  dat_w,
		input  sel,
		input  we,
		input  cyc,
		input  stb,
		output dat_r,
		output ack
	);

endinterface

/* hw/pci_target_fsm.sv */
`timescale 1ns/100ps

module pci_target_fsm #(
	parameter pci_target_pkg::addr_t BASE_ADDR = 32'h0000_1000,
	parameter int                    MEM_WORDS = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  frame,
	input  logic                  irdy,
	input  pci_target_pkg::addr_t ad,
	input  pci_target_pkg::be_t   c_be,
	input  logic                  last_xfer,
	input  logic                  wb_done,
	input  pci_target_pkg::data_t rd_word,
	output logic                  load,
	output logic                  advance,
	output logic                  wb_start,
	output logic                  wb_we,
	output pci_target_pkg::data_t ad_out,
	output logic                  trdy,
	output logic                  devsel,
	output logic                  stop,
	output logic                  ad_oe,
	output pci_target_pkg::cmd_t  cmd
);
	import pci_target_pkg::*;

	localparam addr_t WIN_BYTES = addr_t'(MEM_WORDS * 4);  // Window size in bytes

	typedef enum logic [2:0] {
		idle,                                     // Bus free
		decode,                                   // Claimed or not, also reissues reads
		wr_wait,                                  // trdy low, waiting for irdy
		wr_busy,                                  // Wishbone write running
		rd_fetch,                                 // Wishbone read running
		rd_ready,                                 // Word on ad_out, trdy low
		halt,                                     // stop held until frame rises
		terminate                                 // Release devsel, trdy, stop and ad
	} state_t;

	state_t state;
	addr_t  offset;                               // Address relative to window base
	logic   in_win;
	logic   cmd_ok;
	logic   xfer;                                 // Data moves on this edge

	////////////////////////////////////////////////////////////////////////////
	// Address decode and handshake terms
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		offset = ad - BASE_ADDR;                  // Wraps high for addresses below base
		in_win = offset < WIN_BYTES;
		cmd_ok = (c_be == CMD_MEM_READ) || (c_be == CMD_MEM_WRITE) ||
			(c_be == CMD_MEM_READ_MULT) || (c_be == CMD_MEM_READ_LINE);
	end

	assign xfer     = !irdy && !trdy;
	assign load     = (state == idle) && !frame;  // Address phase edge
	assign advance  = xfer && ((state == wr_wait) || (state == rd_ready));
	assign wb_we    = (cmd == CMD_MEM_WRITE);
	// Writes start at the transfer edge, reads start from decode with a claimed bus
	assign wb_start = ((state == wr_wait) && xfer) ||
		((state == decode) && !devsel && !wb_we);

	////////////////////////////////////////////////////////////////////////////
	// Target state machine
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state  <= idle;
			cmd    <= '0;
			trdy   <= 1'b1;
			devsel <= 1'b1;
			stop   <= 1'b1;
			ad_oe  <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
					if (!frame)
					begin
						cmd   <= c_be;            // Command held for whole burst
						state <= decode;
						if (in_win && cmd_ok)
						begin
							devsel <= 1'b0;       // Fast decode
							if (ad[1:0] != 2'b00)
							begin
								stop  <= 1'b0;    // Reserved mode, disconnect without data
								state <= halt;
							end
						end
					end
				decode:
					if (devsel)
					begin
						if (frame)
							state <= idle;        // Master abort finished
					end
					else if (wb_we)
					begin
						trdy  <= 1'b0;            // Bridge idle so ready for first word
						stop  <= ~last_xfer;
						state <= wr_wait;
					end
					else
						state <= rd_fetch;
				wr_wait:
					if (xfer)
					begin
						trdy <= 1'b1;
						if (frame)
							state <= terminate;   // Master's last phase
						else if (last_xfer)
							state <= halt;        // stop was low with this transfer
						else
							state <= wr_busy;
					end
				wr_busy:
					if (wb_done)
					begin
						trdy  <= 1'b0;
						stop  <= ~last_xfer;
						state <= wr_wait;
					end
				rd_fetch:
					if (wb_done)
					begin
						trdy  <= 1'b0;
						ad_oe <= 1'b1;
						stop  <= ~last_xfer;
						state <= rd_ready;
					end
				rd_ready:
					if (xfer)
					begin
						trdy <= 1'b1;
						if (frame)
							state <= terminate;
						else if (last_xfer)
							state <= halt;
						else
							state <= decode;      // Prefetch next word
					end
				halt:
					if (frame)
						state <= terminate;
				terminate:
				begin
					trdy   <= 1'b1;
					devsel <= 1'b1;
					stop   <= 1'b1;
					ad_oe  <= 1'b0;
					state  <= idle;
				end
				default:
					state <= idle;
			endcase
		end
	end

	// Read word held on ad until the master takes it
	always_ff @(posedge clk)
	begin
		if ((state == rd_fetch) && wb_done)
			ad_out <= rd_word;
	end

	a_trdy_claimed: assert property (@(posedge clk) disable iff (!rst)
		!trdy |-> !devsel);

endmodule

/* hw/pci_burst_addr.sv */
`timescale 1ns/100ps

module pci_burst_addr #(
	parameter pci_target_pkg::addr_t BASE_ADDR = 32'h0000_1000,
	parameter int                    MEM_WORDS = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  logic                  advance,
	input  pci_target_pkg::addr_t ad,
	input  pci_target_pkg::cmd_t  cmd,
	output pci_target_pkg::addr_t addr,
	output logic                  last_xfer
);
	import pci_target_pkg::*;

	localparam addr_t TOP_ADDR = BASE_ADDR + addr_t'((MEM_WORDS - 1) * 4);  // Last word

	burst_cnt_t word_cnt;                         // Counts the current word too
	logic       rd_limit;
	logic       line_limit;

	////////////////////////////////////////////////////////////////////////////
	// Word counter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst)
			word_cnt <= '0;
		else if (load)
			word_cnt <= burst_cnt_t'(1);          // First data phase
		else if (advance && (word_cnt != '1))
			word_cnt <= word_cnt + burst_cnt_t'(1);  // Saturates on long bursts
	end

	// Linear burst address
	always_ff @(posedge clk)
	begin
		if (load)
			addr <= ad;
		else if (advance)
			addr <= addr + addr_t'(4);
	end

	////////////////////////////////////////////////////////////////////////////
	// Last allowed transfer
	////////////////////////////////////////////////////////////////////////////
	assign rd_limit   = (cmd == CMD_MEM_READ) && (word_cnt == burst_cnt_t'(MEM_R_WORDS));
	assign line_limit = (cmd == CMD_MEM_READ_LINE) && (word_cnt == burst_cnt_t'(LINE_WORDS));
	assign last_xfer  = (addr == TOP_ADDR) || rd_limit || line_limit;

endmodule

/* hw/pci_wb_master.sv */
`timescale 1ns/100ps

module pci_wb_master (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  logic                  we,
	input  pci_target_pkg::addr_t addr,
	input  pci_target_pkg::data_t wdata,
	input  pci_target_pkg::be_t   be,
	output logic                  done,
	output pci_target_pkg::data_t rdata,
	wb_if.master                  wb
);
	import pci_target_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Cycle control
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			wb.cyc <= 1'b0;
			wb.stb <= 1'b0;
			done   <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				wb.cyc <= 1'b1;                   // cyc and stb rise together
				wb.stb <= 1'b1;
			end
			else if (wb.ack)
			begin
				wb.cyc <= 1'b0;
				wb.stb <= 1'b0;
				done   <= 1'b1;                   // One pulse in the cycle after ack
			end
		end
	end

	// Request held steady until ack
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			wb.adr   <= addr;
			wb.dat_w <= wdata;
			wb.sel   <= ~be;                      // PCI lanes are low active
			wb.we    <= we;
		end
		if (wb.ack)
			rdata <= wb.dat_r;
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst)
		wb.stb |-> wb.cyc);
	// Target FSM issues one cycle at a time
	a_one_cycle: assert property (@(posedge clk) disable iff (!rst)
		start |-> !wb.cyc);

endmodule

/* hw/target_sram.sv */
`timescale 1ns/100ps

module target_sram #(
	parameter pci_target_pkg::addr_t BASE_ADDR = 32'h0000_1000,
	parameter int                    MEM_WORDS = 64
) (
	input  logic clk,
	input  logic rst,
	wb_if.slave  wb
);
	import pci_target_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	data_t             mem [MEM_WORDS];           // Word storage
	addr_t             offset;
	logic [IDX_W-1:0]  idx;                       // Word index inside window
	logic              req;                       // First strobe cycle

	assign offset = wb.adr - BASE_ADDR;
	assign idx    = offset[IDX_W+1:2];
	assign req    = wb.cyc && wb.stb && !wb.ack;

	// One wait state then ack for a single cycle
	always_ff @(posedge clk)
	begin
		if (!rst)
			wb.ack <= 1'b0;
		else
			wb.ack <= req;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory array with byte lanes
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (req)
		begin
			if (wb.we)
				for (int i = 0; i < 4; i++)
					if (wb.sel[i])
						mem[idx][8*i +: 8] <= wb.dat_w[8*i +: 8];
			wb.dat_r <= mem[idx];                 // Valid in the ack cycle
		end
	end

	a_ack_in_stb: assert property (@(posedge clk) disable iff (!rst)
		wb.ack |-> wb.stb);

endmodule

/* hw/pci_target.sv */
`timescale 1ns/100ps

module pci_target #(
	parameter pci_target_pkg::addr_t BASE_ADDR = 32'h0000_1000,
	parameter int                    MEM_WORDS = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  frame,
	input  logic                  irdy,
	input  pci_target_pkg::addr_t ad,
	input  pci_target_pkg::be_t   c_be,
	output logic                  trdy,
	output logic                  devsel,
	output logic                  stop,
	output logic                  ad_oe,
	output pci_target_pkg::data_t ad_out
);
	import pci_target_pkg::*;

	logic  load;                                  // Address phase
	logic  advance;                               // Transfer edge
	logic  wb_start;
	logic  wb_we;
	logic  wb_done;
	logic  last_xfer;
	addr_t addr;                                  // Current burst address
	data_t rd_word;
	cmd_t  cmd;

	wb_if wb ();                                  // Bridge to memory

	////////////////////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////////////////////
	pci_target_fsm #(.BASE_ADDR(BASE_ADDR), .MEM_WORDS(MEM_WORDS)) i_fsm (
		.clk(clk), .rst(rst), .frame(frame), .irdy(irdy), .ad(ad), .c_be(c_be),
		.last_xfer(last_xfer), .wb_done(wb_done), .rd_word(rd_word),
		.load(load), .advance(advance), .wb_start(wb_start), .wb_we(wb_we),
		.ad_out(ad_out), .trdy(trdy), .devsel(devsel), .stop(stop), .ad_oe(ad_oe),
		.cmd(cmd)
	);

	pci_burst_addr #(.BASE_ADDR(BASE_ADDR), .MEM_WORDS(MEM_WORDS)) i_addr (
		.clk(clk), .rst(rst), .load(load), .advance(advance), .ad(ad), .cmd(cmd),
		.addr(addr), .last_xfer(last_xfer)
	);

	// Write data and byte enables come straight from the bus
	pci_wb_master i_wb_master (
		.clk(clk), .rst(rst), .start(wb_start), .we(wb_we), .addr(addr),
		.wdata(ad), .be(c_be), .done(wb_done), .rdata(rd_word), .wb(wb.master)
	);

	target_sram #(.BASE_ADDR(BASE_ADDR), .MEM_WORDS(MEM_WORDS)) i_sram (
		.clk(clk), .rst(rst), .wb(wb.slave)
	);

endmodule

/* test/tb_pci_tasks.svh */
////////////////////////////////////////////////////////////////////////////
// PCI master side of the testbench
////////////////////////////////////////////////////////////////////////////

// Put data phase k on the bus, reads enable all lanes
task automatic drive_data(input bit is_rd, input int k);
	ad   = is_rd ? '0 : wr_data[k];
	c_be = is_rd ? '0 : wr_be[k];
endtask

// One address phase followed by up to len data phases
task automatic run_burst(input cmd_t cmd, input addr_t a, input int len, input bit claim);
	int idx;
	int k;
	int stop_at;
	int exp_n;
	bit done;
	bit is_rd;
	bit got_stop;
	is_rd    = (cmd != CMD_MEM_WRITE);
	stop_at  = ref_stop(cmd, a);                  // 0 means stop without data
	exp_n    = (len < stop_at) ? len : stop_at;
	idx      = 0;
	got_stop = 1'b0;
	done     = 1'b0;
	if (is_rd && claim)
		ref_read(a, exp_n);
	@(negedge clk);
	frame = 1'b0;                                 // Address phase
	irdy  = 1'b1;
	ad    = a;
	c_be  = cmd;
	@(negedge clk);
	if (!claim)
	begin
		frame = 1'b1;                             // Master abort
		ad    = '0;
		c_be  = '0;
		for (k = 0; k < 5; k++)
		begin
			if (!devsel)
				fail_plain("devsel asserted for an unclaimed address phase");
			@(negedge clk);
		end
	end
	else
	begin
		if (devsel)
		begin
			fail_plain("devsel did not assert");
			done = 1'b1;
		end
		rd_active = is_rd;
		irdy      = 1'b0;
		frame     = (len == 1);                   // Single phase ends at once
		drive_data(is_rd, 0);
		while (!done)
		begin
			if (!trdy)
			begin
				idx++;                            // Transfer on the coming edge
				if (stop !== ((idx == stop_at) ? 1'b0 : 1'b1))
					value_error("stop", (idx == stop_at) ? 32'd0 : 32'd1, 32'(stop));
				if (!is_rd)
					apply_write(a + addr_t'(4 * (idx - 1)), wr_data[idx-1], wr_be[idx-1]);
				done = !stop || (idx >= len);
			end
			else if (!stop)
			begin
				got_stop = 1'b1;                  // Disconnect without data
				done     = 1'b1;
			end
			@(negedge clk);
			if (!done)
			begin
				frame = (idx >= len - 1);
				drive_data(is_rd, idx);
			end
		end
		frame     = 1'b1;
		irdy      = 1'b1;
		ad        = '0;
		c_be      = '0;
		rd_active = 1'b0;
		if (idx != exp_n)
			value_error("transfer count", 32'(exp_n), 32'(idx));
		if ((stop_at == 0) && !got_stop)
			fail_plain("stop missing for reserved address mode");
		if (exp_q.size() != 0)
		begin
			fail_plain("expected read words were never transferred");
			exp_q.delete();
		end
	end
	repeat (3) @(negedge clk);                    // Bus idle gap
endtask

/* test/tb_pci_target.sv */
`timescale 1ns/100ps

module tb_pci_target;
	import pci_target_pkg::*;

	localparam addr_t BASE_ADDR    = 32'h0000_1000;
	localparam int    MEM_WORDS    = 64;
	localparam addr_t TOP_ADDR     = BASE_ADDR + addr_t'((MEM_WORDS - 1) * 4);
	localparam int    PLAN_XFERS   = 98;          // Data phases over all bursts
	localparam int    CYCLE_LIMIT  = 20 * PLAN_XFERS + 200;

	logic   clk;
	logic   rst;
	logic   frame;
	logic   irdy;
	addr_t  ad;
	be_t    c_be;
	logic   trdy;
	logic   devsel;
	logic   stop;
	logic   ad_oe;
	data_t  ad_out;

	data_t  mdl [MEM_WORDS];                      // Model memory
	data_t  wr_data [MEM_WORDS];                  // Write data per phase
	be_t    wr_be [MEM_WORDS];                    // Low active lanes per phase
	data_t  exp_q [$];                            // Expected read words
	logic   rd_active;
	int     errors;
	int     cycles;
	integer seed;
	int     i;

	pci_target #(.BASE_ADDR(BASE_ADDR), .MEM_WORDS(MEM_WORDS)) i_dut (
		.clk(clk), .rst(rst), .frame(frame), .irdy(irdy), .ad(ad), .c_be(c_be),
		.trdy(trdy), .devsel(devsel), .stop(stop), .ad_oe(ad_oe), .ad_out(ad_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reporting and reference model
	////////////////////////////////////////////////////////////////////////////
	task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] got);
		$display("** Error at %0t: %s expected %h got %h", $time, sig, exp, got);
		errors++;
	endtask

	task automatic fail_plain(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errors++;
	endtask

	function automatic int word_idx(input addr_t a);
		return int'((a - BASE_ADDR) >> 2);
	endfunction

	// Transfer number that carries stop, 0 for the reserved mode
	function automatic int ref_stop(input cmd_t cmd, input addr_t a);
		int lim;
		if (a[1:0] != 2'b00)
			return 0;
		lim = int'((TOP_ADDR - a) >> 2) + 1;       // Words up to the window top
		if ((cmd == CMD_MEM_READ) && (lim > 2))
			lim = 2;
		if ((cmd == CMD_MEM_READ_LINE) && (lim > 4))
			lim = 4;
		return lim;
	endfunction

	function automatic void ref_read(input addr_t a, input int n);
		for (int k = 0; k < n; k++)
			exp_q.push_back(mdl[word_idx(a) + k]);
	endfunction

	function automatic void apply_write(input addr_t a, input data_t d, input be_t be);
		for (int b = 0; b < 4; b++)
			if (!be[b])
				mdl[word_idx(a)][8*b +: 8] = d[8*b +: 8];
	endfunction

	function automatic data_t fill_word(input addr_t a);
		return {a[15:0] ^ 16'h5a3c, a[31:16] ^ ~a[15:0]};
	endfunction

	`include "tb_pci_tasks.svh"

	////////////////////////////////////////////////////////////////////////////
	// Clock, timeout and read compare
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;                   // 100 ns period
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	always @(posedge clk)
	begin
		if (rd_active && !irdy && !trdy)
		begin
			if (ad_oe !== 1'b1)
				fail_plain("ad_oe low during a read transfer");
			if (exp_q.size() == 0)
				fail_plain("read transfer beyond the expected words");
			else if (ad_out !== exp_q[0])
				value_error("ad_out", exp_q.pop_front(), ad_out);
			else
				void'(exp_q.pop_front());
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		rst       = 1'b0;
		frame     = 1'b1;
		irdy      = 1'b1;
		ad        = '0;
		c_be      = '0;
		rd_active = 1'b0;
		errors    = 0;
		cycles    = 0;
		seed      = 32'h0bd0c6a3;
		repeat (8) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		if (trdy !== 1'b1)
			value_error("trdy", 32'd1, 32'(trdy));
		if (devsel !== 1'b1)
			value_error("devsel", 32'd1, 32'(devsel));
		if (stop !== 1'b1)
			value_error("stop", 32'd1, 32'(stop));
		if (ad_oe !== 1'b0)
			value_error("ad_oe", 32'd0, 32'(ad_oe));
		for (i = 0; i < MEM_WORDS; i++)
		begin
			wr_data[i] = fill_word(BASE_ADDR + addr_t'(4 * i));
			wr_be[i]   = 4'h0;
		end
		run_burst(CMD_MEM_WRITE, BASE_ADDR, MEM_WORDS, 1'b1);  // Whole window known
		for (i = 0; i < 6; i++)
		begin
			wr_data[i] = $random(seed);
			wr_be[i]   = (i == 0) ? 4'h0 : be_t'($random(seed));  // Mixed lanes
		end
		run_burst(CMD_MEM_WRITE, BASE_ADDR + 32'h10, 6, 1'b1);
		run_burst(CMD_MEM_READ_MULT, BASE_ADDR + 32'h10, 6, 1'b1);
		run_burst(CMD_MEM_READ, BASE_ADDR + 32'h28, 4, 1'b1);     // Stops after 2
		run_burst(CMD_MEM_READ_LINE, BASE_ADDR + 32'h40, 6, 1'b1); // Stops after 4
		for (i = 0; i < 4; i++)
		begin
			wr_data[i] = $random(seed);
			wr_be[i]   = 4'h0;
		end
		run_burst(CMD_MEM_WRITE, TOP_ADDR - 32'h8, 4, 1'b1);       // Hits window top
		run_burst(CMD_MEM_READ_MULT, TOP_ADDR - 32'h8, 4, 1'b1);
		run_burst(CMD_MEM_WRITE, BASE_ADDR - 32'h10, 2, 1'b0);     // Below window
		run_burst(4'b0010, BASE_ADDR + 32'h10, 2, 1'b0);          // Unsupported command
		run_burst(CMD_MEM_READ_MULT, BASE_ADDR + 32'h10, 6, 1'b1);
		run_burst(CMD_MEM_WRITE, BASE_ADDR + 32'h12, 2, 1'b1);     // Reserved mode
		run_burst(CMD_MEM_READ_MULT, BASE_ADDR + 32'h10, 4, 1'b1);
		$display("Run complete, %0d errors", errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* pci_target.f */
+incdir+test
hw/pci_target_pkg.sv
hw/wb_if.sv
hw/pci_target_fsm.sv
hw/pci_burst_addr.sv
hw/pci_wb_master.sv
hw/target_sram.sv
hw/pci_target.sv
test/tb_pci_target.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PCI target testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_pci_target \
	-f pci_target.f \
	-o sim_pci_target

out=$(./obj_dir/sim_pci_target)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'
